//--- source/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address width
`define CACHE_ADDR_BITS 32

// byte offset within a 32-byte line
`define CACHE_OFFSET_BITS 5

// 8 lines per cache
`define CACHE_INDEX_BITS 3

// whatever is left of the address
`define CACHE_TAG_BITS (`CACHE_ADDR_BITS - `CACHE_OFFSET_BITS - `CACHE_INDEX_BITS)

`define CACHE_LINE_BITS 256

`define CACHE_WORD_BITS 32

`endif

//--- source/cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_BITS-1:0] addr_t;

    typedef logic [`CACHE_WORD_BITS-1:0] word_t;

    typedef logic [`CACHE_LINE_BITS-1:0] line_t;

    // one enable bit per byte of a word
    typedef logic [`CACHE_WORD_BITS/8-1:0] byte_en_t;

    typedef logic [`CACHE_TAG_BITS-1:0] tag_t;

    // owner of the shared memory port
    typedef enum logic {
        grant_icache,
        grant_dcache
    } grant_t;

endpackage

//--- source/word_lane_unit.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module word_lane_unit
    import cache_pkg::*;
(
    input  line_t                        line,
    input  logic [`CACHE_OFFSET_BITS-1:0] offset,
    input  word_t                        wdata,
    input  byte_en_t                     byte_enable,
    output word_t                        word,
    output line_t                        merged_line
);

    localparam int word_bytes = `CACHE_WORD_BITS / 8;

    // word slot from the upper offset bits
    logic [`CACHE_OFFSET_BITS-3:0] word_sel;

    assign word_sel = offset[`CACHE_OFFSET_BITS-1:2];

    always_comb begin
        word = line[word_sel*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];
    end

    always_comb begin
        merged_line = line;
        for (int b = 0; b < word_bytes; b++) begin
            if (byte_enable[b]) begin
                merged_line[word_sel*`CACHE_WORD_BITS + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

endmodule

//--- source/cache_core.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_core
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     read,
    input  logic     write,
    input  addr_t    address,
    input  byte_en_t byte_enable,
    input  word_t    wdata,
    output word_t    rdata,
    output logic     resp,
    output logic     mem_read,
    output logic     mem_write,
    output addr_t    mem_address,
    output line_t    mem_wdata,
    input  line_t    mem_rdata,
    input  logic     mem_resp
);

    localparam int num_lines = 2 ** `CACHE_INDEX_BITS;

    typedef enum logic [1:0] {
        st_idle,
        st_compare,
        st_writeback,
        st_fill
    } state_t;

    state_t state;
    state_t state_next;

    line_t                data_array [num_lines];
    tag_t                 tag_array  [num_lines];
    logic [num_lines-1:0] valid_bits;
    logic [num_lines-1:0] dirty_bits;

    tag_t                         addr_tag;
    logic [`CACHE_INDEX_BITS-1:0] index;
    logic [`CACHE_OFFSET_BITS-1:0] offset;
    line_t                        cur_line;
    line_t                        merged_line;
    logic                         hit;
    logic                         fill_done;

    assign addr_tag = address[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
    assign index = address[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
    assign offset = address[`CACHE_OFFSET_BITS-1:0];
    assign cur_line = data_array[index];
    assign hit = valid_bits[index] && (tag_array[index] == addr_tag);
    assign fill_done = (state == st_fill) && mem_resp;

    // read word and write merge both come from the indexed line
    word_lane_unit lanes (
        .line        (cur_line),
        .offset      (offset),
        .wdata       (wdata),
        .byte_enable (byte_enable),
        .word        (rdata),
        .merged_line (merged_line)
    );

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (read || write) begin
                    state_next = st_compare;
                end
            end
            st_compare: begin
                if (hit || !(read || write)) begin
                    state_next = st_idle;
                end else if (valid_bits[index] && dirty_bits[index]) begin
                    state_next = st_writeback;
                end else begin
                    state_next = st_fill;
                end
            end
            st_writeback: begin
                if (mem_resp) begin
                    state_next = st_fill;
                end
            end
            st_fill: begin
                // retry as a hit once the line is in
                if (mem_resp) begin
                    state_next = st_compare;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    assign resp = (state == st_compare) && hit && (read || write);
    assign mem_read = (state == st_fill);
    assign mem_write = (state == st_writeback);
    assign mem_wdata = cur_line;

    // victim goes back to its own line address
    assign mem_address = (state == st_writeback) ?
                         {tag_array[index], index, {`CACHE_OFFSET_BITS{1'b0}}} :
                         {addr_tag, index, {`CACHE_OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            state <= state_next;
            if (fill_done) begin
                valid_bits[index] <= 1'b1;
                dirty_bits[index] <= 1'b0;
            end else if (resp && write) begin
                dirty_bits[index] <= 1'b1;
            end
        end
    end

    // line data and tags
    always_ff @(posedge clk) begin
        if (fill_done) begin
            data_array[index] <= mem_rdata;
            tag_array[index] <= addr_tag;
        end else if (resp && write) begin
            data_array[index] <= merged_line;
        end
    end

endmodule

//--- source/cache_arbiter.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_arbiter
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  icache_mem_read,
    input  addr_t icache_mem_address,
    output logic  icache_mem_resp,
    output line_t icache_mem_rdata,

    input  logic  dcache_mem_read,
    input  logic  dcache_mem_write,
    input  addr_t dcache_mem_address,
    input  line_t dcache_mem_wdata,
    output logic  dcache_mem_resp,
    output line_t dcache_mem_rdata,

    output logic  pmem_read,
    output logic  pmem_write,
    output addr_t pmem_address,
    output line_t pmem_wdata,
    input  line_t pmem_rdata,
    input  logic  pmem_resp
);

    typedef enum logic {
        arb_idle,
        arb_busy
    } arb_state_t;

    arb_state_t state;
    grant_t     grant;
    logic       dcache_req;

    assign dcache_req = dcache_mem_read || dcache_mem_write;

    // data cache wins a tie
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arb_idle;
            grant <= grant_dcache;
        end else if (state == arb_idle) begin
            if (dcache_req) begin
                state <= arb_busy;
                grant <= grant_dcache;
            end else if (icache_mem_read) begin
                state <= arb_busy;
                grant <= grant_icache;
            end
        end else if (pmem_resp) begin
            state <= arb_idle;
        end
    end

    always_comb begin
        pmem_read = 1'b0;
        pmem_write = 1'b0;
        icache_mem_resp = 1'b0;
        dcache_mem_resp = 1'b0;
        if (grant == grant_dcache) begin
            pmem_address = dcache_mem_address;
        end else begin
            pmem_address = icache_mem_address;
        end
        if (state == arb_busy) begin
            if (grant == grant_dcache) begin
                pmem_read = dcache_mem_read;
                pmem_write = dcache_mem_write;
                dcache_mem_resp = pmem_resp;
            end else begin
                pmem_read = icache_mem_read;
                icache_mem_resp = pmem_resp;
            end
        end
    end

    // only the data cache ever writes back
    assign pmem_wdata = dcache_mem_wdata;
    assign icache_mem_rdata = pmem_rdata;
    assign dcache_mem_rdata = pmem_rdata;

endmodule

//--- source/cache_hierarchy.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_hierarchy
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     imem_read,
    input  addr_t    imem_address,
    output word_t    imem_rdata,
    output logic     imem_resp,

    input  logic     dmem_read,
    input  logic     dmem_write,
    input  addr_t    dmem_address,
    input  byte_en_t dmem_byte_enable,
    input  word_t    dmem_wdata,
    output word_t    dmem_rdata,
    output logic     dmem_resp,

    output logic     pmem_read,
    output logic     pmem_write,
    output addr_t    pmem_address,
    output line_t    pmem_wdata,
    input  line_t    pmem_rdata,
    input  logic     pmem_resp
);

    logic  icache_mem_read;
    addr_t icache_mem_address;
    logic  icache_mem_resp;
    line_t icache_mem_rdata;

    logic  dcache_mem_read;
    logic  dcache_mem_write;
    addr_t dcache_mem_address;
    line_t dcache_mem_wdata;
    logic  dcache_mem_resp;
    line_t dcache_mem_rdata;

    // read-only, so the write side is tied off
    cache_core icache_core (
        .clk         (clk),
        .rst         (rst),
        .read        (imem_read),
        .write       (1'b0),
        .address     (imem_address),
        .byte_enable ('0),
        .wdata       ('0),
        .rdata       (imem_rdata),
        .resp        (imem_resp),
        .mem_read    (icache_mem_read),
        .mem_write   (),
        .mem_address (icache_mem_address),
        .mem_wdata   (),
        .mem_rdata   (icache_mem_rdata),
        .mem_resp    (icache_mem_resp)
    );

    cache_core dcache_core (
        .clk         (clk),
        .rst         (rst),
        .read        (dmem_read),
        .write       (dmem_write),
        .address     (dmem_address),
        .byte_enable (dmem_byte_enable),
        .wdata       (dmem_wdata),
        .rdata       (dmem_rdata),
        .resp        (dmem_resp),
        .mem_read    (dcache_mem_read),
        .mem_write   (dcache_mem_write),
        .mem_address (dcache_mem_address),
        .mem_wdata   (dcache_mem_wdata),
        .mem_rdata   (dcache_mem_rdata),
        .mem_resp    (dcache_mem_resp)
    );

    cache_arbiter arbiter (
        .*
    );

endmodule

//--- tests/cache_hierarchy_chk.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_hierarchy_chk
    import cache_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  imem_resp,
    input logic  dmem_resp,
    input logic  pmem_read,
    input logic  pmem_write,
    input logic  pmem_resp,
    input addr_t pmem_address
);

    // resp is a single-cycle pulse
    imem_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        imem_resp |=> !imem_resp) else $error("imem_resp high for two cycles");

    dmem_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        dmem_resp |=> !dmem_resp) else $error("dmem_resp high for two cycles");

    pmem_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write)) else $error("pmem_read and pmem_write both high");

    // request levels hold until the memory answers
    pmem_read_hold: assert property (@(posedge clk) disable iff (rst)
        pmem_read && !pmem_resp |=> pmem_read && $stable(pmem_address))
        else $error("pmem_read dropped or moved before pmem_resp");

    pmem_write_hold: assert property (@(posedge clk) disable iff (rst)
        pmem_write && !pmem_resp |=> pmem_write && $stable(pmem_address))
        else $error("pmem_write dropped or moved before pmem_resp");

    reset_quiet: assert property (@(posedge clk)
        rst |=> !(imem_resp || dmem_resp || pmem_read || pmem_write))
        else $error("control output high right after reset");

endmodule

bind cache_hierarchy cache_hierarchy_chk handshake_chk (.*);

//--- tests/cache_hierarchy_tb.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_hierarchy_tb
    import cache_pkg::*;
();

    localparam int clk_period = 20;
    localparam int directed_requests = 9;
    localparam int random_requests = 200;
    localparam int miss_bound = 40;
    localparam addr_t ibase = 32'h0001_0000;
    localparam addr_t dbase = 32'h0008_0000;

    logic     clk;
    logic     rst;
    logic     imem_read;
    addr_t    imem_address;
    word_t    imem_rdata;
    logic     imem_resp;
    logic     dmem_read;
    logic     dmem_write;
    addr_t    dmem_address;
    byte_en_t dmem_byte_enable;
    word_t    dmem_wdata;
    word_t    dmem_rdata;
    logic     dmem_resp;
    logic     pmem_read;
    logic     pmem_write;
    addr_t    pmem_address;
    line_t    pmem_wdata;
    line_t    pmem_rdata;
    logic     pmem_resp;

    // expected memory image from completed data writes
    logic [7:0] shadow [addr_t];
    line_t      mem_lines [addr_t];
    addr_t      pmem_log [$];
    addr_t      last_wb_address;
    string      test_name;
    int         issued_count;
    int         resp_count;

    cache_hierarchy UUT (.*);

    function automatic word_t init_word(addr_t a);
        addr_t w;
        w = {a[31:2], 2'b00};
        return w ^ {w[15:0], w[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic line_t init_line(addr_t la);
        line_t l;
        for (int w = 0; w < 8; w++) begin
            l[w*32 +: 32] = init_word(la + addr_t'(w*4));
        end
        return l;
    endfunction

    function automatic logic [7:0] shadow_byte(addr_t a);
        word_t w;
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        w = init_word(a);
        return w[{a[1:0], 3'b000} +: 8];
    endfunction

    function automatic word_t ref_word(addr_t a);
        word_t r;
        for (int b = 0; b < 4; b++) begin
            r[b*8 +: 8] = shadow_byte({a[31:2], 2'b00} + addr_t'(b));
        end
        return r;
    endfunction

    function automatic addr_t line_of(addr_t a);
        return {a[31:`CACHE_OFFSET_BITS], {`CACHE_OFFSET_BITS{1'b0}}};
    endfunction

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_word(string what, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_addr(string what, addr_t expected, addr_t actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(string what, logic expected, logic actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %b, actual %b", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic icache_read(input addr_t a, output int cycles);
        @(posedge clk);
        #1;
        issued_count++;
        imem_read = 1'b1;
        imem_address = a;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!imem_resp);
        @(posedge clk);
        #1;
        imem_read = 1'b0;
    endtask

    task automatic dcache_access(input logic wr, input addr_t a, input byte_en_t be,
                                 input word_t d, output int cycles);
        @(posedge clk);
        #1;
        issued_count++;
        dmem_read = !wr;
        dmem_write = wr;
        dmem_address = a;
        dmem_byte_enable = be;
        dmem_wdata = d;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!dmem_resp);
        @(posedge clk);
        #1;
        dmem_read = 1'b0;
        dmem_write = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    // pmem answers after 1 to 4 cycles
    initial begin : pmem_model
        addr_t la;
        logic  is_write;
        int    delay;
        pmem_resp = 1'b0;
        pmem_rdata = '0;
        forever begin
            @(negedge clk);
            if (pmem_read || pmem_write) begin
                la = pmem_address;
                is_write = pmem_write;
                pmem_log.push_back(la);
                if (is_write) begin
                    last_wb_address = la;
                    for (int w = 0; w < 8; w++) begin
                        check_word("writeback data", ref_word(la + addr_t'(w*4)),
                                   pmem_wdata[w*32 +: 32]);
                    end
                    mem_lines[la] = pmem_wdata;
                end
                delay = int'($urandom_range(4, 1));
                repeat (delay) @(posedge clk);
                #1;
                if (!is_write) begin
                    pmem_rdata = mem_lines.exists(la) ? mem_lines[la] : init_line(la);
                end
                pmem_resp = 1'b1;
                @(posedge clk);
                #1;
                pmem_resp = 1'b0;
            end
        end
    end

    initial begin : compare_proc
        addr_t wa;
        forever begin
            @(negedge clk);
            if (imem_resp) begin
                resp_count++;
                check_word("icache read", ref_word(imem_address), imem_rdata);
            end
            if (dmem_resp && dmem_read) begin
                resp_count++;
                check_word("dcache read", ref_word(dmem_address), dmem_rdata);
            end
            if (dmem_resp && dmem_write) begin
                resp_count++;
                wa = {dmem_address[31:2], 2'b00};
                for (int b = 0; b < 4; b++) begin
                    if (dmem_byte_enable[b]) begin
                        shadow[wa + addr_t'(b)] = dmem_wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    initial begin : watchdog
        repeat ((directed_requests + random_requests) * miss_bound) @(posedge clk);
        $display("timeout: requests did not finish within the cycle budget");
        abort_run();
    end

    initial begin : stimulus
        int       c1;
        int       c2;
        int       reqs;
        int       kind;
        addr_t    ia;
        addr_t    da;
        byte_en_t be;
        word_t    wd;
        void'($urandom(86822));
        rst = 1'b1;
        imem_read = 1'b0;
        imem_address = '0;
        dmem_read = 1'b0;
        dmem_write = 1'b0;
        dmem_address = '0;
        dmem_byte_enable = '0;
        dmem_wdata = '0;
        issued_count = 0;
        resp_count = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "reset";
        @(negedge clk);
        check_flag("imem_resp", 1'b0, imem_resp);
        check_flag("dmem_resp", 1'b0, dmem_resp);
        check_flag("pmem_read", 1'b0, pmem_read);
        check_flag("pmem_write", 1'b0, pmem_write);
        pmem_log.delete();
        icache_read(ibase + 32'h24, c1);
        check_addr("fill address", ibase + 32'h20, pmem_log[0]);

        test_name = "hit after fill";
        reqs = pmem_log.size();
        icache_read(ibase + 32'h28, c1);
        check_word("hit cycles", 32'd2, word_t'(c1));
        check_word("pmem requests", word_t'(reqs), word_t'(pmem_log.size()));

        test_name = "byte write";
        dcache_access(1'b1, dbase + 32'h14, 4'b0110, 32'hdead_beef, c1);
        dcache_access(1'b0, dbase + 32'h14, '0, '0, c1);

        test_name = "dirty eviction";
        last_wb_address = '1;
        dcache_access(1'b1, dbase + 32'h44, 4'hf, 32'h1234_5678, c1);
        dcache_access(1'b0, dbase + 32'h144, '0, '0, c1);
        check_addr("writeback address", dbase + 32'h40, last_wb_address);
        dcache_access(1'b0, dbase + 32'h44, '0, '0, c1);

        test_name = "simultaneous misses";
        pmem_log.delete();
        fork
            icache_read(ibase + 32'h1c4, c1);
            dcache_access(1'b0, dbase + 32'h3a8, '0, '0, c2);
        join
        check_word("pmem requests", 32'd2, word_t'(pmem_log.size()));
        check_addr("first pmem request", dbase + 32'h3a0, pmem_log[0]);
        check_addr("second pmem request", ibase + 32'h1c0, pmem_log[1]);

        test_name = "random mix";
        for (int n = 0; n < random_requests; n++) begin
            kind = int'($urandom_range(3, 0));
            ia = ibase + addr_t'($urandom_range(15, 0)) * 32 + addr_t'($urandom_range(7, 0)) * 4;
            da = dbase + addr_t'($urandom_range(31, 0)) * 32 + addr_t'($urandom_range(7, 0)) * 4;
            be = byte_en_t'($urandom_range(15, 1));
            wd = $urandom;
            case (kind)
                0: icache_read(ia, c1);
                1: dcache_access(1'b0, da, '0, '0, c1);
                2: dcache_access(1'b1, da, be, wd, c1);
                default: begin
                    fork
                        icache_read(ia, c1);
                        dcache_access(1'b1, line_of(da) + 32'h8, be, wd, c2);
                    join
                end
            endcase
        end

        test_name = "response count";
        check_word("responses", word_t'(issued_count), word_t'(resp_count));
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+source
source/cache_pkg.sv
source/word_lane_unit.sv
source/cache_core.sv
source/cache_arbiter.sv
source/cache_hierarchy.sv
tests/cache_hierarchy_chk.sv
tests/cache_hierarchy_tb.sv

//--- Makefile
TOOL       = verilator
TOP        = cache_hierarchy_tb
FILELIST   = sources.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
